// ==== rtl/z80_bus_pkg.sv ====
package z80_bus_pkg;

	// ----------------------------------------------------------------------
	//	Bus widths
	// ----------------------------------------------------------------------
	typedef logic [15:0]	addr_t;			// Z80 address
	typedef logic [7:0]		data_t;			// One bus byte
	typedef logic [9:0]		ram_addr_t;		// 1 KiB work RAM index
	typedef logic [3:0]		rom_addr_t;		// 16-byte boot ROM index

	// ----------------------------------------------------------------------
	//	Address map
	// ----------------------------------------------------------------------
	// Compared against a[15:14] on memory cycles
	localparam logic [1:0]	ROM_BANK	= 2'b00;
	localparam logic [1:0]	RAM_BANK	= 2'b01;

	// I/O port, compared against a[7:0]
	localparam logic [7:0]	UART_PORT	= 8'h10;

	// Nothing drives the bus
	localparam logic [7:0]	OPEN_BUS	= 8'hFF;

	// ----------------------------------------------------------------------
	//	Clock division
	// ----------------------------------------------------------------------
	localparam logic [2:0]	CPU_DIV		= 3'd6;	// Clocks per CPU enable
	localparam logic [2:0]	UART_DIV	= 3'd4;	// Peripheral enables per bit

	// ----------------------------------------------------------------------
	//	UART transmitter states
	// ----------------------------------------------------------------------
	typedef enum logic [1:0] {
		IDLE,		// Line high, waiting for a write
		START,		// Start bit, line low
		DATA,		// Eight data bits, LSB first
		STOP		// Stop bit, line high
	} uart_state_t;

endpackage

// ==== rtl/clock_enable_gen.sv ====
`timescale 1ns/10ps

module clock_enable_gen (
	input	logic	clk,
	input	logic	ff_reset_n,
	output	logic	periph_enable,		// High every 2nd clock
	output	logic	cpu_enable			// High 1 clock in CPU_DIV
);
	import z80_bus_pkg::*;

	logic			ff_toggle;
	logic	[2:0]	ff_cpu_cnt;			// Runs 0 .. CPU_DIV-1
	logic			ff_cpu_enable;

	// Half-rate toggle, doubles as the peripheral enable
	always_ff @(posedge clk) begin
		if (!ff_reset_n) begin
			ff_toggle <= 1'b0;
		end else begin
			ff_toggle <= ~ff_toggle;
		end
	end

	// CPU divider, pulse registered on the wrap so it lands on the 6th edge
	always_ff @(posedge clk) begin
		if (!ff_reset_n) begin
			ff_cpu_cnt		<= 3'd0;
			ff_cpu_enable	<= 1'b0;
		end else begin
			ff_cpu_enable <= (ff_cpu_cnt == CPU_DIV - 3'd1);
			if (ff_cpu_cnt == CPU_DIV - 3'd1) begin
				ff_cpu_cnt <= 3'd0;			// Wrap
			end else begin
				ff_cpu_cnt <= ff_cpu_cnt + 3'd1;
			end
		end
	end

	assign periph_enable	= ff_toggle;
	assign cpu_enable		= ff_cpu_enable;

	// Period is CPU_DIV, never a double-wide pulse
	a_cpu_enable_single: assert property (
		@(posedge clk) disable iff (!ff_reset_n) cpu_enable |=> !cpu_enable
	) else $error("cpu_enable high on two clocks in a row");

endmodule

// ==== rtl/bus_decoder.sv ====
`timescale 1ns/10ps

module bus_decoder (
	input	logic					mreq_n,
	input	logic					iorq_n,
	input	z80_bus_pkg::addr_t		a,
	input	z80_bus_pkg::data_t		rom_q,
	input	logic					rom_q_en,
	input	z80_bus_pkg::data_t		ram_q,
	input	logic					ram_q_en,
	input	z80_bus_pkg::data_t		uart_q,
	input	logic					uart_q_en,
	output	logic					rom_cs_n,
	output	logic					ram_cs_n,
	output	logic					uart_cs_n,
	output	z80_bus_pkg::data_t		rdata,
	output	logic					rdata_en
);
	import z80_bus_pkg::*;

	// ----------------------------------------------------------------------
	//	Chip selects
	// ----------------------------------------------------------------------
	// Memory banks on the top two address bits
	assign rom_cs_n		= !(!mreq_n && (a[15:14] == ROM_BANK));
	assign ram_cs_n		= !(!mreq_n && (a[15:14] == RAM_BANK));

	// I/O space uses only the low byte of the address
	assign uart_cs_n	= !(!iorq_n && (a[7:0] == UART_PORT));

	// ----------------------------------------------------------------------
	//	Read data mux
	// ----------------------------------------------------------------------
	// Fixed priority, UART first
	always_comb begin
		rdata		= OPEN_BUS;			// Unmapped reads float high
		rdata_en	= 1'b1;
		if (uart_q_en) begin
			rdata = uart_q;
		end else if (rom_q_en) begin
			rdata = rom_q;
		end else if (ram_q_en) begin
			rdata = ram_q;
		end else begin
			rdata_en = 1'b0;			// Nobody answered
		end
	end

	// Selects are exclusive, so only one peripheral may answer
	always_comb begin
		a_one_responder: assert final ($onehot0({uart_q_en, rom_q_en, ram_q_en}))
			else $error("More than one peripheral drives read data");
	end

endmodule

// ==== rtl/boot_rom.sv ====
`timescale 1ns/10ps

module boot_rom (
	input	logic						clk,
	input	logic						cs_n,
	input	logic						rd_n,
	input	z80_bus_pkg::rom_addr_t		address,	// Bank folds onto 4 bits
	output	z80_bus_pkg::data_t			q,
	output	logic						q_en
);
	import z80_bus_pkg::*;

	data_t		mem [0:15];
	data_t		ff_q;
	logic		ff_q_en;
	logic		w_read;

	// Image with the greeting, padded to 16 bytes
	initial begin
		$readmemh("rtl/boot_rom.hex", mem);
	end

	assign w_read = !cs_n && !rd_n;

	// Valid follows the read strobe one clock later
	always_ff @(posedge clk) begin
		ff_q_en <= w_read;
	end

	// Byte latched only during a read
	always_ff @(posedge clk) begin
		if (w_read) begin
			ff_q <= mem[address];
		end
	end

	assign q	= ff_q;
	assign q_en	= ff_q_en;

endmodule

// ==== rtl/work_ram.sv ====
`timescale 1ns/10ps

module work_ram (
	input	logic						clk,
	input	logic						cs_n,
	input	logic						rd_n,
	input	logic						wr_n,
	input	z80_bus_pkg::ram_addr_t		address,	// Bank folds onto 10 bits
	input	z80_bus_pkg::data_t			wdata,
	output	z80_bus_pkg::data_t			q,
	output	logic						q_en
);
	import z80_bus_pkg::*;

	data_t		mem [0:1023];
	data_t		ff_q;
	logic		ff_q_en;
	logic		w_read;
	logic		w_write;

	assign w_read	= !cs_n && !rd_n;
	assign w_write	= !cs_n && !wr_n;

	// ----------------------------------------------------------------------
	//	Storage
	// ----------------------------------------------------------------------
	// Written on every clock of the strobe, last one wins
	always_ff @(posedge clk) begin
		if (w_write) begin
			mem[address] <= wdata;
		end
	end

	// Registered read port
	always_ff @(posedge clk) begin
		if (w_read) begin
			ff_q <= mem[address];
		end
	end

	always_ff @(posedge clk) begin
		ff_q_en <= w_read;			// Drops the edge after the read ends
	end

	assign q	= ff_q;
	assign q_en	= ff_q_en;

	// Bus master must not assert both strobes
	a_no_rd_wr_overlap: assert property (
		@(posedge clk) !cs_n |-> (rd_n || wr_n)
	) else $error("RAM selected with rd_n and wr_n both low");

endmodule

// ==== rtl/uart_tx_port.sv ====
`timescale 1ns/10ps

module uart_tx_port (
	input	logic					clk,
	input	logic					ff_reset_n,
	input	logic					enable,		// Peripheral half-rate enable
	input	logic					cs_n,
	input	logic					rd_n,
	input	logic					wr_n,
	input	z80_bus_pkg::data_t		wdata,
	input	logic	[1:0]			button,
	output	z80_bus_pkg::data_t		q,
	output	logic					q_en,
	output	logic					uart_tx
);
	import z80_bus_pkg::*;

	uart_state_t	ff_state;
	data_t			ff_shift;			// Bits still to send
	logic	[2:0]	ff_div_cnt;			// Enables within one bit
	logic	[2:0]	ff_bit_cnt;			// Data bit index
	logic			ff_tx;
	logic			ff_wr_active;		// Write strobe seen last clock
	logic	[1:0]	ff_btn_meta;
	logic	[1:0]	ff_btn_sync;
	data_t			ff_q;
	logic			ff_q_en;
	logic			w_wr_start;
	logic			w_bit_end;
	logic			w_busy;

	// ----------------------------------------------------------------------
	//	Bus side
	// ----------------------------------------------------------------------
	// Leading edge of the write, only while idle
	assign w_wr_start	= !cs_n && !wr_n && !ff_wr_active && (ff_state == IDLE);
	assign w_busy		= (ff_state != IDLE);

	always_ff @(posedge clk) begin
		if (!ff_reset_n) begin
			ff_wr_active	<= 1'b0;
			ff_q_en			<= 1'b0;
		end else begin
			ff_wr_active	<= !cs_n && !wr_n;
			ff_q_en			<= !cs_n && !rd_n;
		end
	end

	// Status byte and button synchronizer
	always_ff @(posedge clk) begin
		ff_btn_meta	<= button;
		ff_btn_sync	<= ff_btn_meta;
		ff_q		<= {w_busy, 5'd0, ff_btn_sync};		// Busy in bit 7
	end

	// ----------------------------------------------------------------------
	//	Transmitter
	// ----------------------------------------------------------------------
	assign w_bit_end = enable && (ff_div_cnt == UART_DIV - 3'd1);

	always_ff @(posedge clk) begin
		if (!ff_reset_n) begin
			ff_state	<= IDLE;
			ff_tx		<= 1'b1;				// Line idles high
			ff_div_cnt	<= 3'd0;
			ff_bit_cnt	<= 3'd0;
		end else begin
			if (ff_state == IDLE || w_bit_end) begin
				ff_div_cnt <= 3'd0;
			end else if (enable) begin
				ff_div_cnt <= ff_div_cnt + 3'd1;
			end
			case (ff_state)
				IDLE: if (w_wr_start) begin
					ff_state	<= START;
					ff_tx		<= 1'b0;			// Start bit
				end
				START: if (w_bit_end) begin
					ff_state	<= DATA;
					ff_tx		<= ff_shift[0];		// LSB first
					ff_bit_cnt	<= 3'd0;
				end
				DATA: if (w_bit_end) begin
					if (ff_bit_cnt == 3'd7) begin
						ff_state	<= STOP;
						ff_tx		<= 1'b1;		// Stop bit
					end else begin
						ff_tx		<= ff_shift[0];
						ff_bit_cnt	<= ff_bit_cnt + 3'd1;
					end
				end
				default: if (w_bit_end) begin
					ff_state	<= IDLE;
				end
			endcase
		end
	end

	// Byte loaded on accept, moved down as each bit goes out
	always_ff @(posedge clk) begin
		if (w_wr_start) begin
			ff_shift <= wdata;
		end else if (w_bit_end && (ff_state == START || ff_state == DATA)) begin
			ff_shift <= ff_shift >> 1;
		end
	end

	assign uart_tx	= ff_tx;
	assign q		= ff_q;
	assign q_en		= ff_q_en;

	// Line held at mark between frames
	a_idle_line_high: assert property (
		@(posedge clk) disable iff (!ff_reset_n) (ff_state == IDLE) |-> uart_tx
	) else $error("uart_tx low while transmitter idle");

endmodule

// ==== rtl/z80_bus_system.sv ====
`timescale 1ns/10ps

module z80_bus_system (
	input	logic					clk,
	input	logic					ff_reset_n,
	input	logic					mreq_n,
	input	logic					iorq_n,
	input	logic					rd_n,
	input	logic					wr_n,
	input	z80_bus_pkg::addr_t		a,
	input	z80_bus_pkg::data_t		wdata,
	input	logic	[1:0]			button,
	output	z80_bus_pkg::data_t		rdata,
	output	logic					rdata_en,
	output	logic					cpu_enable,	// For the bus master
	output	logic					uart_tx
);
	import z80_bus_pkg::*;

	logic		w_periph_enable;
	logic		w_rom_cs_n;
	data_t		w_rom_q;
	logic		w_rom_q_en;
	logic		w_ram_cs_n;
	data_t		w_ram_q;
	logic		w_ram_q_en;
	logic		w_uart_cs_n;
	data_t		w_uart_q;
	logic		w_uart_q_en;

	// ----------------------------------------------------------------------
	//	Clock enables
	// ----------------------------------------------------------------------
	clock_enable_gen u_clock_enable_gen (
		.clk			( clk				),
		.ff_reset_n		( ff_reset_n		),
		.periph_enable	( w_periph_enable	),
		.cpu_enable		( cpu_enable		)
	);

	// ----------------------------------------------------------------------
	//	Decode and read mux
	// ----------------------------------------------------------------------
	bus_decoder u_bus_decoder (
		.mreq_n			( mreq_n			),
		.iorq_n			( iorq_n			),
		.a				( a					),
		.rom_q			( w_rom_q			),
		.rom_q_en		( w_rom_q_en		),
		.ram_q			( w_ram_q			),
		.ram_q_en		( w_ram_q_en		),
		.uart_q			( w_uart_q			),
		.uart_q_en		( w_uart_q_en		),
		.rom_cs_n		( w_rom_cs_n		),
		.ram_cs_n		( w_ram_cs_n		),
		.uart_cs_n		( w_uart_cs_n		),
		.rdata			( rdata				),
		.rdata_en		( rdata_en			)
	);

	// ----------------------------------------------------------------------
	//	Memories
	// ----------------------------------------------------------------------
	boot_rom u_boot_rom (
		.clk			( clk				),
		.cs_n			( w_rom_cs_n		),
		.rd_n			( rd_n				),
		.address		( a[3:0]			),	// Mirrors across bank 0
		.q				( w_rom_q			),
		.q_en			( w_rom_q_en		)
	);

	work_ram u_work_ram (
		.clk			( clk				),
		.cs_n			( w_ram_cs_n		),
		.rd_n			( rd_n				),
		.wr_n			( wr_n				),
		.address		( a[9:0]			),	// Mirrors across bank 1
		.wdata			( wdata				),
		.q				( w_ram_q			),
		.q_en			( w_ram_q_en		)
	);

	// ----------------------------------------------------------------------
	//	Serial port
	// ----------------------------------------------------------------------
	uart_tx_port u_uart_tx_port (
		.clk			( clk				),
		.ff_reset_n		( ff_reset_n		),
		.enable			( w_periph_enable	),
		.cs_n			( w_uart_cs_n		),
		.rd_n			( rd_n				),
		.wr_n			( wr_n				),
		.wdata			( wdata				),
		.button			( button			),
		.q				( w_uart_q			),
		.q_en			( w_uart_q_en		),
		.uart_tx		( uart_tx			)
	);

endmodule

// ==== sim/tb_z80_bus_system.sv ====
`timescale 1ns/10ps

module tb_z80_bus_system;
	import z80_bus_pkg::*;

	localparam int READ_TIMEOUT		= 4;	// Clocks allowed for rdata_en
	localparam int START_TIMEOUT	= 40;	// Clocks allowed for a start bit
	localparam int BUSY_POLLS		= 8;	// Status reads before giving up

	logic			clk;
	logic			ff_reset_n;
	logic			mreq_n;
	logic			iorq_n;
	logic			rd_n;
	logic			wr_n;
	addr_t			a;
	data_t			wdata;
	logic	[1:0]	button;
	data_t			rdata;
	logic			rdata_en;
	logic			cpu_enable;
	logic			uart_tx;

	data_t			rom_ref [0:15];		// Reference image
	data_t			ram_model [0:1023];	// Last byte written per index
	logic	[15:0]	lfsr_state;
	string			current_test;
	int				checks;
	int				errors;
	int				tests;
	int				test_checks;
	int				test_errors;

	z80_bus_system z80_bus_system_inst (
		.clk			( clk			),
		.ff_reset_n		( ff_reset_n	),
		.mreq_n			( mreq_n		),
		.iorq_n			( iorq_n		),
		.rd_n			( rd_n			),
		.wr_n			( wr_n			),
		.a				( a				),
		.wdata			( wdata			),
		.button			( button		),
		.rdata			( rdata			),
		.rdata_en		( rdata_en		),
		.cpu_enable		( cpu_enable	),
		.uart_tx		( uart_tx		)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;			// 20 ns period
	end

	// ----------------------------------------------------------------------
	//	Stimulus helpers
	// ----------------------------------------------------------------------
	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// One LFSR step per bit taken
	function automatic logic [15:0] random_bits(input int n);
		logic	[15:0]	v;
		int				i;
		v = 16'h0000;
		for (i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[14:0], lfsr_state[0]};
		end
		return v;
	endfunction

	task automatic check_byte(input string what, input data_t expected, input data_t actual);
		checks++;
		assert (actual === expected) else begin
			$display("error %s %s: expected %h, actual %h", current_test, what, expected, actual);
			errors++;
		end
	endtask

	task automatic check_bit(input string what, input logic expected, input logic actual);
		checks++;
		assert (actual === expected) else begin
			$display("error %s %s: expected %b, actual %b", current_test, what, expected, actual);
			errors++;
		end
	endtask

	task automatic start_test(input string name);
		current_test	= name;
		test_checks		= checks;
		test_errors		= errors;
	endtask

	task automatic end_test();
		tests++;
		$display("test %s: %0d checks, %0d errors", current_test,
			checks - test_checks, errors - test_errors);
	endtask

	// Starts and ends 2 ns after a rising edge with one idle clock at the end
	task automatic bus_read(input logic io, input addr_t addr, output data_t data,
			output logic valid);
		int		edges;
		edges	= 0;
		valid	= 1'b0;
		data	= OPEN_BUS;
		a		= addr;
		rd_n	= 1'b0;
		if (io) begin
			iorq_n = 1'b0;
		end else begin
			mreq_n = 1'b0;
		end
		while (!valid && edges < READ_TIMEOUT) begin
			@(posedge clk);
			edges++;
			@(negedge clk);				// Sample away from the edge
			data	= rdata;
			valid	= rdata_en;
		end
		@(posedge clk);
		edges++;
		while (edges < 3) begin			// Minimum strobe width
			@(posedge clk);
			edges++;
		end
		#2;
		mreq_n	= 1'b1;
		iorq_n	= 1'b1;
		rd_n	= 1'b1;
		@(posedge clk);
		#2;
	endtask

	task automatic bus_write(input logic io, input addr_t addr, input data_t data);
		a		= addr;
		wdata	= data;
		wr_n	= 1'b0;
		if (io) begin
			iorq_n = 1'b0;
		end else begin
			mreq_n = 1'b0;
		end
		repeat (3) @(posedge clk);
		#2;
		mreq_n	= 1'b1;
		iorq_n	= 1'b1;
		wr_n	= 1'b1;
		@(posedge clk);					// Idle clock between accesses
		#2;
	endtask

	// Serial line checker sampling mid-bit every 8 clocks
	task automatic receive_frame(output logic found, output logic start_bit,
			output data_t data, output logic stop_bit);
		int		n;
		int		i;
		found		= 1'b0;
		start_bit	= 1'b1;
		stop_bit	= 1'b0;
		data		= 8'h00;
		n			= 0;
		while (!found && n < START_TIMEOUT) begin
			@(negedge clk);
			n++;
			found = !uart_tx;
		end
		if (found) begin
			repeat (4) @(negedge clk);
			start_bit = uart_tx;
			for (i = 0; i < 8; i++) begin
				repeat (8) @(negedge clk);
				data[i] = uart_tx;			// LSB first
			end
			repeat (8) @(negedge clk);
			stop_bit = uart_tx;
		end
	endtask

	// ----------------------------------------------------------------------
	//	Bus assertions
	// ----------------------------------------------------------------------
	a_open_bus: assert property (
		@(posedge clk) disable iff (!ff_reset_n) !rdata_en |-> (rdata == OPEN_BUS)
	) else begin
		$display("error %s open bus: expected %h, actual %h", current_test, OPEN_BUS,
			$sampled(rdata));
		errors++;
	end

	// ----------------------------------------------------------------------
	//	Test sequence
	// ----------------------------------------------------------------------
	initial begin
		data_t			rd;
		data_t			tx_byte;
		data_t			rx_byte;
		data_t			port;
		logic			ok;
		logic			found;
		logic			start_bit;
		logic			stop_bit;
		logic			line_low;
		logic	[15:0]	r;
		addr_t			addr;
		addr_t			wr_addrs [0:19];
		int				i;
		int				n;

		lfsr_state		= 16'd94;
		checks			= 0;
		errors			= 0;
		tests			= 0;
		current_test	= "reset";
		ff_reset_n		= 1'b0;
		mreq_n			= 1'b1;
		iorq_n			= 1'b1;
		rd_n			= 1'b1;
		wr_n			= 1'b1;
		a				= 16'h0000;
		wdata			= 8'h00;
		button			= 2'b00;
		$readmemh("rtl/boot_rom.hex", rom_ref);
		repeat (8) @(posedge clk);
		#2;
		ff_reset_n = 1'b1;

		start_test("reset_enables");
		check_bit("uart_tx", 1'b1, uart_tx);
		check_bit("rdata_en", 1'b0, rdata_en);
		check_bit("cpu_enable", 1'b0, cpu_enable);
		for (i = 1; i <= 24; i++) begin
			@(posedge clk);
			@(negedge clk);
			check_bit("cpu_enable", (i % 6 == 0), cpu_enable);	// One pulse per 6 edges
		end
		@(posedge clk);
		#2;
		end_test();

		// Second pass sets upper bits inside bank 0
		start_test("rom_read");
		for (i = 0; i < 32; i++) begin
			r = (i < 16) ? 16'h0000 : random_bits(10);
			addr = {ROM_BANK, r[9:0], i[3:0]};
			bus_read(1'b0, addr, rd, ok);
			check_bit("rdata_en", 1'b1, ok);
			check_byte("rom byte", rom_ref[i[3:0]], rd);
		end
		end_test();

		// 20 writes into 16 slots overwrite some indices
		start_test("ram_write_read");
		for (i = 0; i < 20; i++) begin
			r = random_bits(16);
			addr = {RAM_BANK, r[15:12], 6'b101101, r[3:0]};
			bus_write(1'b0, addr, r[11:4]);
			ram_model[addr[9:0]] = r[11:4];
			wr_addrs[i] = addr;
		end
		for (i = 0; i < 20; i++) begin
			r = random_bits(4);
			addr = {RAM_BANK, r[3:0], wr_addrs[i][9:0]};		// Other mirror
			bus_read(1'b0, addr, rd, ok);
			check_bit("rdata_en", 1'b1, ok);
			check_byte("ram byte", ram_model[addr[9:0]], rd);
		end
		end_test();

		start_test("open_bus");
		r = random_bits(15);
		bus_read(1'b0, {1'b1, r[14:0]}, rd, ok);		// Banks 2 and 3 unmapped
		check_bit("memory rdata_en", 1'b0, ok);
		check_byte("memory rdata", OPEN_BUS, rd);
		r = random_bits(16);
		port = (r[7:0] == UART_PORT) ? 8'h11 : r[7:0];
		bus_read(1'b1, {r[15:8], port}, rd, ok);
		check_bit("io rdata_en", 1'b0, ok);
		check_byte("io rdata", OPEN_BUS, rd);
		end_test();

		start_test("uart_frame");
		r = random_bits(8);
		tx_byte = r[7:0];
		fork
			receive_frame(found, start_bit, rx_byte, stop_bit);
			begin
				bus_write(1'b1, {8'h00, UART_PORT}, tx_byte);
				bus_read(1'b1, {8'h00, UART_PORT}, rd, ok);
				check_bit("status rdata_en", 1'b1, ok);
				check_byte("status busy", {1'b1, 5'd0, button}, rd);
				bus_write(1'b1, {8'h00, UART_PORT}, ~tx_byte);	// Lands mid-frame and is dropped
			end
		join
		checks++;
		assert (found) else begin
			$display("No start bit appeared on uart_tx after the port write");
			errors++;
		end
		check_bit("start bit", 1'b0, start_bit);
		check_byte("data bits", tx_byte, rx_byte);
		check_bit("stop bit", 1'b1, stop_bit);
		@(posedge clk);
		#2;
		n	= 0;
		rd	= 8'h80;
		while (rd[7] && n < BUSY_POLLS) begin
			bus_read(1'b1, {8'h00, UART_PORT}, rd, ok);
			n++;
		end
		check_byte("status idle", {1'b0, 5'd0, button}, rd);
		line_low = 1'b0;
		for (i = 0; i < 100; i++) begin		// A full frame time of quiet line
			@(negedge clk);
			line_low = line_low | !uart_tx;
		end
		checks++;
		assert (!line_low) else begin
			$display("A second UART frame followed the write made during the first");
			errors++;
		end
		@(posedge clk);
		#2;
		end_test();

		start_test("buttons");
		for (i = 0; i < 2; i++) begin
			r = random_bits(2);
			button = (r[1:0] == button) ? ~button : r[1:0];	// Always a change
			repeat (3) @(posedge clk);					// Through the synchronizer
			#2;
			bus_read(1'b1, {8'h00, UART_PORT}, rd, ok);
			check_bit("status rdata_en", 1'b1, ok);
			check_byte("status buttons", {1'b0, 5'd0, button}, rd);
		end
		end_test();

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// ==== rtl/boot_rom.hex ====
// One byte per line, ASCII "Hello, world!" then zero padding to 16 bytes
48
65
6C
6C
6F
2C
20
77
6F
72
6C
64
21
00
00
00

// ==== files.f ====
rtl/z80_bus_pkg.sv
rtl/clock_enable_gen.sv
rtl/bus_decoder.sv
rtl/boot_rom.sv
rtl/work_ram.sv
rtl/uart_tx_port.sv
rtl/z80_bus_system.sv
sim/tb_z80_bus_system.sv

// ==== Makefile ====
VERILATOR	= verilator
VFLAGS		= --binary --timing --assert -j 0 --timescale 1ns/10ps
TOP			= tb_z80_bus_system
FILELIST	= files.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir
